// ==== filelist.f ====
logic/mips_pkg.sv
logic/mem_req_if.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_lsu.sv
logic/mips_control.sv
logic/mips_cpu_bus.sv
tests/tb_avalon_mem.sv
tests/tb_mips_cpu_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu_bus
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_TEXT ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ns

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS    = 5;
    localparam int MAX_LEN      = 20;
    // Fetch and exec each stretched by two wait states, plus decode and mem
    localparam int WORST_CPI    = 8;
    localparam int IDLE_CYCLES  = 10;
    localparam int RUN_CYCLES   = MAX_LEN * WORST_CPI + RESET_CYCLES + IDLE_CYCLES + 2;
    // One extra run for the reset test
    localparam int WATCHDOG_CYCLES = (NUM_TESTS + 1) * RUN_CYCLES;

    localparam reg_idx_t ZERO = 5'd0;
    localparam reg_idx_t V0   = 5'd2;
    localparam reg_idx_t T0   = 5'd8;
    localparam reg_idx_t T1   = 5'd9;
    localparam reg_idx_t T2   = 5'd10;
    localparam reg_idx_t T3   = 5'd11;
    localparam reg_idx_t T4   = 5'd12;
    localparam reg_idx_t T5   = 5'd13;
    localparam reg_idx_t T6   = 5'd14;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    string test_name [NUM_TESTS];
    word_t prog      [NUM_TESTS][MAX_LEN];
    int    prog_len  [NUM_TESTS];
    word_t exp_v0    [NUM_TESTS];
    logic  rerun     [NUM_TESTS];

    int test_errors;
    int pass_count;
    int fail_count;

    mips_cpu_bus i_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    tb_avalon_mem i_mem (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    function automatic word_t rtype_word(funct_t fn, reg_idx_t rs, reg_idx_t rt,
                                         reg_idx_t rd, logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(opcode_t op, logic [25:0] index);
        return {op, index};
    endfunction

    task automatic add_instr(int t, word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t] = prog_len[t] + 1;
    endtask

    // Every program ends with JR $zero and a NOP in its delay slot
    task automatic add_exit(int t);
        add_instr(t, rtype_word(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        add_instr(t, rtype_word(FN_SLL, ZERO, ZERO, ZERO, 5'd0));
    endtask

    task automatic build_table();
        word_t j_dest;
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            rerun[t]    = 1'b0;
        end

        test_name[0] = "arith_logic";
        add_instr(0, itype_word(OP_LUI, ZERO, T0, 16'h1234));
        add_instr(0, itype_word(OP_ORI, T0, T0, 16'h5678));
        add_instr(0, itype_word(OP_ADDIU, ZERO, T1, 16'hFFF0));
        add_instr(0, rtype_word(FN_ADDU, T0, T1, T2, 5'd0));
        add_instr(0, rtype_word(FN_SUBU, T2, T0, T3, 5'd0));
        add_instr(0, rtype_word(FN_AND, T3, T0, T4, 5'd0));
        add_instr(0, rtype_word(FN_XOR, T4, T1, V0, 5'd0));
        add_instr(0, itype_word(OP_SLTI, T1, T5, 16'hFFF1));
        add_instr(0, rtype_word(FN_ADDU, V0, T5, V0, 5'd0));
        add_exit(0);
        // 12345670 ^ fffffff0, then +1 since -16 < -15
        exp_v0[0] = 32'hEDCB_A981;

        test_name[1] = "shift_compare";
        add_instr(1, itype_word(OP_ADDIU, ZERO, T0, 16'h8001));
        add_instr(1, rtype_word(FN_SLL, ZERO, T0, T1, 5'd4));
        add_instr(1, rtype_word(FN_SRL, ZERO, T0, T2, 5'd8));
        add_instr(1, rtype_word(FN_SRA, ZERO, T0, T3, 5'd8));
        add_instr(1, rtype_word(FN_SLT, T0, T2, T4, 5'd0));
        add_instr(1, rtype_word(FN_SLTU, T0, T2, T5, 5'd0));
        add_instr(1, rtype_word(FN_XOR, T1, T2, V0, 5'd0));
        add_instr(1, rtype_word(FN_ADDU, V0, T3, V0, 5'd0));
        add_instr(1, rtype_word(FN_SLL, ZERO, T4, T6, 5'd1));
        add_instr(1, rtype_word(FN_ADDU, T6, T5, T6, 5'd0));
        add_instr(1, rtype_word(FN_ADDU, V0, T6, V0, 5'd0));
        add_exit(1);
        // (fff80010 ^ 00ffff80) + ffffff80, plus 2*slt + sltu = 2
        exp_v0[1] = 32'hFF07_FF12;

        test_name[2] = "store_load";
        add_instr(2, itype_word(OP_ORI, ZERO, T0, 16'h1000));
        add_instr(2, itype_word(OP_LUI, ZERO, T1, 16'h80F1));
        add_instr(2, itype_word(OP_ORI, T1, T1, 16'h7F82));
        add_instr(2, itype_word(OP_SW, T0, T1, 16'd4));
        add_instr(2, itype_word(OP_LW, T0, T2, 16'd4));
        add_instr(2, itype_word(OP_LB, T0, T3, 16'd4));
        add_instr(2, itype_word(OP_LBU, T0, T4, 16'd5));
        add_instr(2, itype_word(OP_LB, T0, T5, 16'd6));
        add_instr(2, itype_word(OP_LBU, T0, T6, 16'd7));
        add_instr(2, rtype_word(FN_SLL, ZERO, T4, T4, 5'd8));
        add_instr(2, rtype_word(FN_SLL, ZERO, T6, T6, 5'd24));
        add_instr(2, rtype_word(FN_XOR, T2, T3, V0, 5'd0));
        add_instr(2, rtype_word(FN_XOR, V0, T4, V0, 5'd0));
        add_instr(2, rtype_word(FN_XOR, V0, T5, V0, 5'd0));
        add_instr(2, rtype_word(FN_XOR, V0, T6, V0, 5'd0));
        add_exit(2);
        // 80f17f82 ^ ffffff82 ^ 00007f00 ^ fffffff1 ^ 80000000
        exp_v0[2] = 32'h00F1_00F1;

        test_name[3] = "delay_slot";
        j_dest = RESET_VECTOR + 32'd44;
        add_instr(3, itype_word(OP_ADDIU, ZERO, V0, 16'd16));
        add_instr(3, itype_word(OP_ADDIU, ZERO, T0, 16'd5));
        add_instr(3, itype_word(OP_ADDIU, ZERO, T1, 16'd5));
        add_instr(3, itype_word(OP_BEQ, T0, T1, 16'd2));
        add_instr(3, itype_word(OP_ADDIU, V0, V0, 16'd1));
        add_instr(3, itype_word(OP_ADDIU, V0, V0, 16'h0100));
        add_instr(3, itype_word(OP_BNE, T0, T1, 16'd3));
        add_instr(3, itype_word(OP_ADDIU, V0, V0, 16'd2));
        add_instr(3, jump_word(OP_J, j_dest[27:2]));
        add_instr(3, itype_word(OP_ADDIU, V0, V0, 16'd4));
        add_instr(3, itype_word(OP_ADDIU, ZERO, V0, 16'h7FFF));
        add_exit(3);
        // 16 + BEQ slot 1 + 2 after untaken BNE + J slot 4
        exp_v0[3] = 32'd23;

        // Bus-heavy program again, halted, then reset and run a second time
        test_name[4] = "halt_reset";
        for (int i = 0; i < prog_len[2]; i++) begin
            prog[4][i] = prog[2][i];
        end
        prog_len[4] = prog_len[2];
        exp_v0[4]   = exp_v0[2];
        rerun[4]    = 1'b1;
    endtask

    task automatic check_word(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_active(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
                     $time, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic load_program(int t);
        i_mem.clear_words();
        for (int i = 0; i < prog_len[t]; i++) begin
            i_mem.load_word(RESET_VECTOR + 32'(4 * i), prog[t][i]);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    task automatic run_program(int t, output int cycles);
        apply_reset();
        @(negedge clk);
        check_active(active, 1'b1, "active after reset");
        check_active(read, 1'b1, "fetch read after reset");
        check_active(write, 1'b0, "write after reset");
        check_word(address, RESET_VECTOR, "first fetch address");
        cycles = 0;
        while (active !== 1'b0) begin
            @(negedge clk);
            cycles++;
        end
        check_word(register_v0, exp_v0[t], "$v0 at halt");
    endtask

    initial begin
        int cycles;
        int first_cycles;

        reset      = 1'b1;
        pass_count = 0;
        fail_count = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            load_program(t);
            run_program(t, cycles);
            first_cycles = cycles;
            if (rerun[t]) begin
                // A halted core stays idle on the bus
                repeat (IDLE_CYCLES) begin
                    @(negedge clk);
                    check_active(active, 1'b0, "active while halted");
                    check_active(read || write, 1'b0, "bus request while halted");
                end
                check_word(register_v0, exp_v0[t], "$v0 while halted");
                load_program(t);
                run_program(t, cycles);
            end
            if (test_errors == 0) begin
                pass_count++;
                $display("PASS %s: v0=%h, runs of %0d and %0d cycles",
                         test_name[t], register_v0, first_cycles, cycles);
            end else begin
                fail_count++;
                $display("FAIL %s: %0d check(s) wrong", test_name[t], test_errors);
            end
        end
        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tests/tb_avalon_mem.sv ====
`timescale 1ns/1ns

// Avalon-MM slave memory with 0 to 2 wait states per transfer
module tb_avalon_mem (
    input  logic            clk,
    input  logic            reset,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output logic            waitrequest,
    output mips_pkg::word_t readdata
);
    import mips_pkg::*;

    localparam int    DRIVE_DELAY = 1;
    localparam word_t LCG_SEED    = 32'hb613afd7;

    // Sparse storage keyed by word-aligned address
    word_t mem [word_t];
    word_t lcg_state;

    function automatic word_t lcg_next(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words read back as a pattern of their address
    function automatic word_t fill_word(word_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic word_t peek_word(word_t a);
        word_t key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return fill_word(key);
    endfunction

    task automatic clear_words();
        mem.delete();
    endtask

    task automatic load_word(word_t a, word_t d);
        mem[{a[31:2], 2'b00}] = d;
    endtask

    task automatic pick_waits(output int n);
        lcg_state = lcg_next(lcg_state);
        n = int'(lcg_state[31:16] % 16'd3);
    endtask

    initial begin
        int    wait_left;
        word_t merged;
        word_t next_data;

        lcg_state   = LCG_SEED;
        wait_left   = 0;
        next_data   = '0;
        waitrequest = 1'b1;
        readdata    = '0;
        forever begin
            @(posedge clk);
            if (reset) begin
                pick_waits(wait_left);
            end else if ((read || write) && !waitrequest) begin
                if (read) begin
                    next_data = peek_word(address);
                    // Lanes the master did not enable carry no valid data
                    for (int b = 0; b < 4; b++) begin
                        if (!byteenable[b]) begin
                            next_data[8*b +: 8] = ~next_data[8*b +: 8];
                        end
                    end
                end else begin
                    merged = peek_word(address);
                    for (int b = 0; b < 4; b++) begin
                        if (byteenable[b]) begin
                            merged[8*b +: 8] = writedata[8*b +: 8];
                        end
                    end
                    mem[{address[31:2], 2'b00}] = merged;
                end
                // Wait states for the next request
                pick_waits(wait_left);
            end else if (read || write) begin
                wait_left = wait_left - 1;
            end
            #DRIVE_DELAY;
            waitrequest = (wait_left != 0);
            readdata    = next_data;
        end
    end

endmodule

// ==== logic/mips_cpu_bus.sv ====
`timescale 1ns/1ns

module mips_cpu_bus #(
    parameter mips_pkg::word_t reset_addr = mips_pkg::RESET_VECTOR
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // Avalon-MM master
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    cpu_state_t state;
    instr_t     ir;
    word_t      pc;
    word_t      rs_val;
    word_t      rt_val;

    // Register writeback from ALU (EXEC) and LSU (MEM)
    logic       alu_we;
    reg_idx_t   alu_idx;
    word_t      alu_data;
    logic       load_we;
    reg_idx_t   load_idx;
    word_t      load_data;

    logic       taken;
    word_t      target;

    mem_req_if mem_req ();

    mips_control #(
        .reset_addr (reset_addr)
    ) i_control (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .taken       (taken),
        .target      (target),
        .mem         (mem_req.ctrl),
        .state       (state),
        .ir          (ir),
        .pc          (pc),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .byteenable  (byteenable),
        .writedata   (writedata)
    );

    mips_regfile i_regfile (
        .clk       (clk),
        .reset     (reset),
        .rs_idx    (ir.r_fields.rs),
        .rt_idx    (ir.r_fields.rt),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .alu_we    (alu_we),
        .alu_idx   (alu_idx),
        .alu_data  (alu_data),
        .load_we   (load_we),
        .load_idx  (load_idx),
        .load_data (load_data),
        .v0        (register_v0)
    );

    mips_alu i_alu (
        .ir      (ir),
        .state   (state),
        .pc      (pc),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .we      (alu_we),
        .wr_idx  (alu_idx),
        .wr_data (alu_data),
        .taken   (taken),
        .target  (target)
    );

    mips_lsu i_lsu (
        .ir       (ir),
        .state    (state),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .readdata (readdata),
        .req      (mem_req.lsu),
        .we       (load_we),
        .wr_idx   (load_idx),
        .wr_data  (load_data)
    );

endmodule

// ==== logic/mips_control.sv ====
`timescale 1ns/1ns

module mips_control #(
    parameter mips_pkg::word_t reset_addr = mips_pkg::RESET_VECTOR
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 waitrequest,
    input  mips_pkg::word_t      readdata,
    input  logic                 taken,
    input  mips_pkg::word_t      target,
    mem_req_if.ctrl              mem,
    output mips_pkg::cpu_state_t state,
    output mips_pkg::instr_t     ir,
    output mips_pkg::word_t      pc,
    output logic                 active,
    output mips_pkg::word_t      address,
    output logic                 read,
    output logic                 write,
    output logic [3:0]           byteenable,
    output mips_pkg::word_t      writedata
);
    import mips_pkg::*;

    logic  mem_op;
    logic  at_halt;
    logic  instr_done;
    logic  pending;
    word_t pending_target;
    word_t pc_next;

    assign mem_op  = mem.load || mem.store;
    assign at_halt = (pc == HALT_ADDR);

    // Last cycle of the current instruction
    assign instr_done = (state == EXEC && !mem_op)
                     || (state == EXEC && mem.store && !waitrequest)
                     || (state == MEM);

    // Delay slot done, so a held branch target takes over
    assign pc_next = pending ? pending_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH;
            active  <= 1'b1;
            pc      <= reset_addr;
            pending <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (at_halt) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC: begin
                    if (!mem_op) begin
                        state <= FETCH;
                    end else if (!waitrequest) begin
                        state <= mem.load ? MEM : FETCH;
                    end
                end
                MEM: state <= FETCH;
                HALTED: state <= HALTED;
                default: state <= HALTED;
            endcase

            if (instr_done) begin
                pc      <= pc_next;
                // Only a branch or jump in EXEC raises taken
                pending <= taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir <= readdata;
        end
        if (state == EXEC && taken) begin
            pending_target <= target;
        end
    end

    // Bus is owned by fetch in FETCH and by the LSU request in EXEC
    always_comb begin
        address    = pc;
        read       = 1'b0;
        write      = 1'b0;
        byteenable = 4'b1111;
        writedata  = mem.wdata;
        case (state)
            FETCH: read = !at_halt;
            EXEC: begin
                if (mem_op) begin
                    address    = mem.addr;
                    read       = mem.load;
                    write      = mem.store;
                    byteenable = mem.byteenable;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/mips_lsu.sv ====
`timescale 1ns/1ns

module mips_lsu (
    input  mips_pkg::instr_t     ir,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::word_t      rs_val,
    input  mips_pkg::word_t      rt_val,
    input  mips_pkg::word_t      readdata,
    mem_req_if.lsu               req,
    output logic                 we,
    output mips_pkg::reg_idx_t   wr_idx,
    output mips_pkg::word_t      wr_data
);
    import mips_pkg::*;

    word_t      eff_addr;
    logic [1:0] lane;
    logic       is_byte;
    logic [7:0] byte_sel;

    // Base plus sign-extended offset
    assign eff_addr = rs_val + {{16{ir.i_fields.imm[15]}}, ir.i_fields.imm};
    assign lane     = eff_addr[1:0];

    assign is_byte = (ir.i_fields.opcode == OP_LB) || (ir.i_fields.opcode == OP_LBU);

    assign req.load  = is_byte || (ir.i_fields.opcode == OP_LW);
    assign req.store = (ir.i_fields.opcode == OP_SW);
    assign req.addr  = {eff_addr[31:2], 2'b00};
    assign req.wdata = rt_val;

    // One lane for byte loads, whole word otherwise
    always_comb begin
        if (is_byte) begin
            req.byteenable = 4'b0001 << lane;
        end else begin
            req.byteenable = 4'b1111;
        end
    end

    always_comb begin
        case (lane)
            2'd0: byte_sel = readdata[7:0];
            2'd1: byte_sel = readdata[15:8];
            2'd2: byte_sel = readdata[23:16];
            default: byte_sel = readdata[31:24];
        endcase
    end

    // Read data is on the bus during MEM
    always_comb begin
        case (ir.i_fields.opcode)
            OP_LB:   wr_data = {{24{byte_sel[7]}}, byte_sel};
            OP_LBU:  wr_data = {24'h000000, byte_sel};
            default: wr_data = readdata;
        endcase
    end

    assign we     = (state == MEM) && req.load;
    assign wr_idx = ir.i_fields.rt;

endmodule

// ==== logic/mips_alu.sv ====
`timescale 1ns/1ns

module mips_alu (
    input  mips_pkg::instr_t     ir,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::word_t      rs_val,
    input  mips_pkg::word_t      rt_val,
    output logic                 we,
    output mips_pkg::reg_idx_t   wr_idx,
    output mips_pkg::word_t      wr_data,
    output logic                 taken,
    output mips_pkg::word_t      target
);
    import mips_pkg::*;

    alu_op_t op;
    logic    use_imm;
    logic    imm_zext;
    logic    dest_rd;
    word_t   imm_ext;
    word_t   opnd_b;
    word_t   pc_plus4;
    logic    is_branch;

    // Decode into an operation and operand sources
    always_comb begin
        op       = ALU_NOP;
        use_imm  = 1'b1;
        imm_zext = 1'b0;
        dest_rd  = 1'b0;
        case (ir.r_fields.opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dest_rd = 1'b1;
                case (ir.r_fields.funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_SLL:  op = ALU_SLL;
                    FN_SRL:  op = ALU_SRL;
                    FN_SRA:  op = ALU_SRA;
                    default: op = ALU_NOP;
                endcase
            end
            OP_ADDIU: op = ALU_ADD;
            OP_SLTI:  op = ALU_SLT;
            OP_ANDI: begin
                op       = ALU_AND;
                imm_zext = 1'b1;
            end
            OP_ORI: begin
                op       = ALU_OR;
                imm_zext = 1'b1;
            end
            OP_XORI: begin
                op       = ALU_XOR;
                imm_zext = 1'b1;
            end
            OP_LUI:  op = ALU_LUI;
            default: op = ALU_NOP;
        endcase
    end

    assign imm_ext = imm_zext ? {16'h0000, ir.i_fields.imm}
                              : {{16{ir.i_fields.imm[15]}}, ir.i_fields.imm};
    assign opnd_b  = use_imm ? imm_ext : rt_val;

    always_comb begin
        case (op)
            ALU_ADD:  wr_data = rs_val + opnd_b;
            ALU_SUB:  wr_data = rs_val - opnd_b;
            ALU_AND:  wr_data = rs_val & opnd_b;
            ALU_OR:   wr_data = rs_val | opnd_b;
            ALU_XOR:  wr_data = rs_val ^ opnd_b;
            ALU_SLT:  wr_data = {31'd0, $signed(rs_val) < $signed(opnd_b)};
            ALU_SLTU: wr_data = {31'd0, rs_val < opnd_b};
            ALU_SLL:  wr_data = rt_val << ir.r_fields.shamt;
            ALU_SRL:  wr_data = rt_val >> ir.r_fields.shamt;
            ALU_SRA:  wr_data = $signed(rt_val) >>> ir.r_fields.shamt;
            ALU_LUI:  wr_data = {ir.i_fields.imm, 16'h0000};
            default:  wr_data = '0;
        endcase
    end

    assign we     = (state == EXEC) && (op != ALU_NOP);
    assign wr_idx = dest_rd ? ir.r_fields.rd : ir.i_fields.rt;

    // Branch and jump resolution
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        is_branch = 1'b0;
        target    = pc_plus4 + {{14{ir.i_fields.imm[15]}}, ir.i_fields.imm, 2'b00};
        case (ir.r_fields.opcode)
            OP_BEQ: is_branch = (rs_val == rt_val);
            OP_BNE: is_branch = (rs_val != rt_val);
            OP_J: begin
                is_branch = 1'b1;
                target    = {pc_plus4[31:28], ir.j_fields.index, 2'b00};
            end
            OP_SPECIAL: begin
                is_branch = (ir.r_fields.funct == FN_JR);
                target    = rs_val;
            end
            default: is_branch = 1'b0;
        endcase
    end

    assign taken = (state == EXEC) && is_branch;

endmodule

// ==== logic/mips_regfile.sv ====
`timescale 1ns/1ns

module mips_regfile (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_idx_t  rs_idx,
    input  mips_pkg::reg_idx_t  rt_idx,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val,
    input  logic                alu_we,
    input  mips_pkg::reg_idx_t  alu_idx,
    input  mips_pkg::word_t     alu_data,
    input  logic                load_we,
    input  mips_pkg::reg_idx_t  load_idx,
    input  mips_pkg::word_t     load_data,
    output mips_pkg::word_t     v0
);
    import mips_pkg::*;

    word_t regs [32];

    // $zero is hardwired
    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];
    assign v0     = regs[2];

    // ALU writes come in EXEC and load writes in MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (alu_we && alu_idx != '0) begin
            regs[alu_idx] <= alu_data;
        end else if (load_we && load_idx != '0) begin
            regs[load_idx] <= load_data;
        end
    end

endmodule

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ns

// Load/store request handed from the LSU to the bus controller
interface mem_req_if;
    import mips_pkg::*;

    logic       load;
    logic       store;
    word_t      addr;
    logic [3:0] byteenable;
    word_t      wdata;

    modport lsu (
        output load, store, addr, byteenable, wdata
    );

    modport ctrl (
        input load, store, addr, byteenable, wdata
    );

endinterface

// ==== logic/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // First fetch after reset
    localparam word_t RESET_VECTOR = 32'hBFC0_0000;
    // Fetching from here ends the program
    localparam word_t HALT_ADDR = 32'h0000_0000;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SW      = 6'h2B
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } j_fields_t;

    // One instruction word, three ways to read it
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        j_fields_t j_fields;
    } instr_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        HALTED
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage
